// File: rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

   // Major opcodes, instr[6:2]
   localparam logic [4:0] OPCODE_LOAD   = 5'b00000;
   localparam logic [4:0] OPCODE_OPIMM  = 5'b00100;
   localparam logic [4:0] OPCODE_AUIPC  = 5'b00101;
   localparam logic [4:0] OPCODE_STORE  = 5'b01000;
   localparam logic [4:0] OPCODE_OP     = 5'b01100;
   localparam logic [4:0] OPCODE_LUI    = 5'b01101;
   localparam logic [4:0] OPCODE_BRANCH = 5'b11000;
   localparam logic [4:0] OPCODE_JALR   = 5'b11001;
   localparam logic [4:0] OPCODE_JAL    = 5'b11011;

   // ALU functions
   localparam logic [2:0] FUNCT3_ADD  = 3'b000;  // ADD/SUB
   localparam logic [2:0] FUNCT3_SLL  = 3'b001;
   localparam logic [2:0] FUNCT3_SLT  = 3'b010;
   localparam logic [2:0] FUNCT3_SLTU = 3'b011;
   localparam logic [2:0] FUNCT3_XOR  = 3'b100;
   localparam logic [2:0] FUNCT3_SR   = 3'b101;  // SRL/SRA
   localparam logic [2:0] FUNCT3_OR   = 3'b110;
   localparam logic [2:0] FUNCT3_AND  = 3'b111;

   // Branch conditions
   localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
   localparam logic [2:0] FUNCT3_BNE  = 3'b001;
   localparam logic [2:0] FUNCT3_BLT  = 3'b100;
   localparam logic [2:0] FUNCT3_BGE  = 3'b101;
   localparam logic [2:0] FUNCT3_BLTU = 3'b110;
   localparam logic [2:0] FUNCT3_BGEU = 3'b111;

   // Access size in bits 1:0, bit 2 set means zero extension
   localparam logic [2:0] FUNCT3_BYTE = 3'b000;
   localparam logic [2:0] FUNCT3_HALF = 3'b001;
   localparam logic [2:0] FUNCT3_WORD = 3'b010;

   typedef union packed {
      struct packed {
         logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
         logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;
      } rType;
      struct packed {
         logic [11:0] imm; logic [4:0] rs1; logic [2:0] funct3;
         logic [4:0] rd; logic [6:0] opcode;
      } iType;
      struct packed {
         logic [6:0] immHi; logic [4:0] rs2; logic [4:0] rs1;
         logic [2:0] funct3; logic [4:0] immLo; logic [6:0] opcode;
      } sType;
      struct packed {
         logic immSign; logic [5:0] immMid; logic [4:0] rs2; logic [4:0] rs1;
         logic [2:0] funct3; logic [3:0] immLow; logic immBit11; logic [6:0] opcode;
      } bType;
      struct packed {
         logic [19:0] imm; logic [4:0] rd; logic [6:0] opcode;
      } uType;
      struct packed {
         logic immSign; logic [9:0] immLow; logic immBit11; logic [7:0] immHigh;
         logic [4:0] rd; logic [6:0] opcode;
      } jType;
   } instrWordT;

   typedef struct packed {
      logic isLoad;   // rd <- mem[rs1+iImm]
      logic isAluImm; // rd <- rs1 OP iImm
      logic isAluReg; // rd <- rs1 OP rs2
      logic isStore;  // mem[rs1+sImm] <- rs2
      logic isLui;
      logic isAuipc;
      logic isBranch;
      logic isJal;
      logic isJalr;
      logic [4:0] rd;
      logic [2:0] funct3;
      logic isSub;    // Only for OP, bit 30 is data in OP-IMM
      logic isSra;
      logic [31:0] iImm;
      logic [31:0] sImm;
      logic [31:0] bImm;
      logic [31:0] uImm;
      logic [31:0] jImm;
   } decodedT;

   typedef struct packed {
      logic [2:0] funct3;
      logic isSub;
      logic isSra;
   } aluOpT;

endpackage

`default_nettype wire

// File: coreBusPkg.sv
`default_nettype none

package coreBusPkg;

   // Internal address bus and adders are this wide
   localparam int ADDR_WIDTH = 24;
   localparam int WORD_WIDTH = 32;
   localparam int ADDR_PAD_WIDTH = WORD_WIDTH - ADDR_WIDTH; // Zero bits above the address

   // First fetch after reset
   localparam logic [WORD_WIDTH-1:0] RESET_ADDR = 32'h0000_0000;

   // Core to memory
   typedef struct packed {
      logic [WORD_WIDTH-1:0] addr;
      logic [WORD_WIDTH-1:0] wdata;
      logic [3:0] wmask;  // Nonzero for one cycle issues a write
      logic rstrb;        // One-cycle read strobe
   } memReqT;

   // Memory to core
   typedef struct packed {
      logic [WORD_WIDTH-1:0] rdata;
      logic rbusy;        // Read data not yet valid
      logic wbusy;        // Write still in progress
   } memRspT;

   // One-hot controller states
   typedef enum logic [4:0] {
      FETCH      = 5'b00001, // Strobe the PC onto the bus
      WAIT_INSTR = 5'b00010, // Latch instruction, start register reads
      EXECUTE    = 5'b00100, // Address adders
      COMMIT     = 5'b01000, // PC update, write-back, memory request
      WAIT_MEM   = 5'b10000  // Wait for rbusy and wbusy low
   } ctrlStateT;

endpackage

`default_nettype wire

// File: rvDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module rvDecoder (
   input  rvIsaPkg::instrWordT instr,
   output rvIsaPkg::decodedT   dec
);
   import rvIsaPkg::*;

   logic [4:0] opcode;

   assign opcode = instr.rType.opcode[6:2]; // Bits 1:0 always 11 in RV32I

   // Instruction classes
   assign dec.isLoad   = (opcode == OPCODE_LOAD);
   assign dec.isAluImm = (opcode == OPCODE_OPIMM);
   assign dec.isAluReg = (opcode == OPCODE_OP);
   assign dec.isStore  = (opcode == OPCODE_STORE);
   assign dec.isLui    = (opcode == OPCODE_LUI);
   assign dec.isAuipc  = (opcode == OPCODE_AUIPC);
   assign dec.isBranch = (opcode == OPCODE_BRANCH);
   assign dec.isJal    = (opcode == OPCODE_JAL);
   assign dec.isJalr   = (opcode == OPCODE_JALR);
   // SYSTEM and anything unknown raise no flag and act as a no-op

   assign dec.rd     = instr.rType.rd;
   assign dec.funct3 = instr.rType.funct3;

   // Bit 30 picks SUB only in register form
   assign dec.isSub = dec.isAluReg & instr.rType.funct7[5];
   // SRA and SRAI both carry bit 30
   assign dec.isSra = instr.rType.funct7[5];

   // I format, 12-bit signed
   assign dec.iImm = {{20{instr.iType.imm[11]}}, instr.iType.imm};

   // S format, split around rd field
   assign dec.sImm = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};

   // B format, halfword offset
   assign dec.bImm = {
      {19{instr.bType.immSign}},
      instr.bType.immSign,
      instr.bType.immBit11,
      instr.bType.immMid,
      instr.bType.immLow,
      1'b0
   };

   // U format, upper 20 bits
   assign dec.uImm = {instr.uType.imm, 12'b0};

   // J format, scrambled 20-bit offset
   assign dec.jImm = {
      {11{instr.jType.immSign}},
      instr.jType.immSign,
      instr.jType.immHigh,
      instr.jType.immBit11,
      instr.jType.immLow,
      1'b0
   };

endmodule

`default_nettype wire

// File: rvAlu.sv
`timescale 1ns/1ps
`default_nettype none

module rvAlu (
   input  logic [31:0]    in1,
   input  logic [31:0]    in2,
   input  rvIsaPkg::aluOpT op,
   output logic [31:0]    result,
   output logic           predicate
);
   import rvIsaPkg::*;

   logic [31:0] sum;
   logic [32:0] diff;        // Bit 32 is the unsigned borrow
   logic        lessSigned;
   logic        lessUnsigned;
   logic        equal;
   logic [31:0] shifterIn;
   logic [32:0] shifted;
   logic [31:0] shiftLeft;

   // Mirror a word, turns the right shifter into a left one
   function automatic logic [31:0] reverse32(input logic [31:0] x);
      logic [31:0] r;
      for (int i = 0; i < 32; i++) begin
         r[i] = x[31-i];
      end
      return r;
   endfunction

   assign sum = in1 + in2;

   // One subtractor for SUB, SLT, SLTU and all branch tests
   assign diff = {1'b1, ~in2} + {1'b0, in1} + 33'd1;

   assign lessUnsigned = diff[32];
   assign lessSigned   = (in1[31] ^ in2[31]) ? in1[31] : diff[32]; // Signs differ, in1 sign decides
   assign equal        = (diff[31:0] == 32'd0);

   // Shared right shifter, 33 bits to carry the fill bit
   assign shifterIn = op.funct3[2] ? in1 : reverse32(in1);
   assign shifted   = $signed({op.isSra & in1[31], shifterIn}) >>> in2[4:0];
   assign shiftLeft = reverse32(shifted[31:0]);

   always_comb begin
      case (op.funct3)
         FUNCT3_ADD:  result = op.isSub ? diff[31:0] : sum;
         FUNCT3_SLL:  result = shiftLeft;
         FUNCT3_SLT:  result = {31'd0, lessSigned};
         FUNCT3_SLTU: result = {31'd0, lessUnsigned};
         FUNCT3_XOR:  result = in1 ^ in2;
         FUNCT3_SR:   result = shifted[31:0];     // SRL or SRA
         FUNCT3_OR:   result = in1 | in2;
         default:     result = in1 & in2;         // AND
      endcase
   end

   // Branch condition from the same compare
   always_comb begin
      case (op.funct3)
         FUNCT3_BEQ:  predicate = equal;
         FUNCT3_BNE:  predicate = !equal;
         FUNCT3_BLT:  predicate = lessSigned;
         FUNCT3_BGE:  predicate = !lessSigned;
         FUNCT3_BLTU: predicate = lessUnsigned;
         FUNCT3_BGEU: predicate = !lessUnsigned;
         default:     predicate = 1'b0;            // 010 and 011 are not branches
      endcase
   end

endmodule

`default_nettype wire

// File: rvLoadStore.sv
`timescale 1ns/1ps
`default_nettype none

module rvLoadStore (
   input  logic [1:0]                       addrLow,
   input  logic [2:0]                       funct3,
   input  logic [coreBusPkg::WORD_WIDTH-1:0] rdata,
   input  logic [coreBusPkg::WORD_WIDTH-1:0] rs2,
   output logic [coreBusPkg::WORD_WIDTH-1:0] loadData,
   output logic [coreBusPkg::WORD_WIDTH-1:0] wdata,
   output logic [3:0]                       wmask
);
   import rvIsaPkg::*;

   logic        byteAccess;
   logic        halfAccess;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   assign byteAccess = (funct3[1:0] == FUNCT3_BYTE[1:0]);
   assign halfAccess = (funct3[1:0] == FUNCT3_HALF[1:0]);

   // Load lane select, memory is word aligned
   assign loadHalf = addrLow[1] ? rdata[31:16] : rdata[15:0];
   assign loadByte = addrLow[0] ? loadHalf[15:8] : loadHalf[7:0];

   // Bit 2 set for LBU/LHU
   assign loadSign = !funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);

   always_comb begin
      case (funct3[1:0])
         FUNCT3_BYTE[1:0]: loadData = {{24{loadSign}}, loadByte};
         FUNCT3_HALF[1:0]: loadData = {{16{loadSign}}, loadHalf};
         FUNCT3_WORD[1:0]: loadData = rdata;
         default:          loadData = rdata;
      endcase
   end

   // Store data, low byte or half copied into every lane it may land in
   assign wdata[7:0]   = rs2[7:0];
   assign wdata[15:8]  = addrLow[0] ? rs2[7:0] : rs2[15:8];
   assign wdata[23:16] = addrLow[1] ? rs2[7:0] : rs2[23:16];
   assign wdata[31:24] = addrLow[0] ? rs2[7:0] :
                         addrLow[1] ? rs2[15:8] : rs2[31:24];

   // Byte enables
   always_comb begin
      if (byteAccess) begin
         wmask = 4'b0001 << addrLow;         // One lane
      end else if (halfAccess) begin
         wmask = addrLow[1] ? 4'b1100 : 4'b0011;
      end else begin
         wmask = 4'b1111;                    // Full word
      end
   end

endmodule

`default_nettype wire

// File: rvRegFile.sv
`timescale 1ns/1ps
`default_nettype none

module rvRegFile (
   input  logic        clk,
   input  logic        rdEn,
   input  logic [4:0]  rs1Idx,
   input  logic [4:0]  rs2Idx,
   output logic [31:0] rs1,
   output logic [31:0] rs2,
   input  logic        wrEn,
   input  logic [4:0]  rdIdx,
   input  logic [31:0] wrData
);

   logic [31:0] regs [32];

   // Write port, x0 never written
   always_ff @(posedge clk) begin
      if (wrEn && rdIdx != 5'd0) begin
         regs[rdIdx] <= wrData;
      end
   end

   // Registered reads, held until the next rdEn
   always_ff @(posedge clk) begin
      if (rdEn) begin
         rs1 <= (rs1Idx == 5'd0) ? 32'd0 : regs[rs1Idx]; // x0 reads zero
         rs2 <= (rs2Idx == 5'd0) ? 32'd0 : regs[rs2Idx];
      end
   end

endmodule

`default_nettype wire

// File: femtoCore.sv
`timescale 1ns/1ps
`default_nettype none

module femtoCore (
   input  logic               clk,
   input  logic               reset,
   output coreBusPkg::memReqT memReq,
   input  coreBusPkg::memRspT memRsp
);
   import rvIsaPkg::*;
   import coreBusPkg::*;

   ctrlStateT             state;
   logic [ADDR_WIDTH-1:0] pc;
   logic [ADDR_WIDTH-1:0] pcPlus4;
   logic [ADDR_WIDTH-1:0] pcImm;
   logic [ADDR_WIDTH-1:0] pcPlusImm;   // Branch, JAL and AUIPC target
   logic [ADDR_WIDTH-1:0] rs1PlusImm;  // JALR target
   logic [ADDR_WIDTH-1:0] lsAddr;      // Load/store address
   logic [ADDR_WIDTH-1:0] nextPc;
   logic                  loadPending; // Load data still to be written back
   instrWordT             fetched;
   instrWordT             instr;
   decodedT               dec;
   logic [31:0]           rs1;
   logic [31:0]           rs2;
   aluOpT                 aluOp;
   logic [31:0]           aluIn2;
   logic [31:0]           aluResult;
   logic                  predicate;
   logic [31:0]           loadData;
   logic [31:0]           storeData;
   logic [3:0]            storeMask;
   logic                  writesRd;
   logic                  rfRdEn;
   logic                  rfWrEn;
   logic [31:0]           rfWrData;
   logic                  instrReady;

   assign fetched    = memRsp.rdata;                         // Raw bus word, seen as an instruction
   assign instrReady = (state == WAIT_INSTR) && !memRsp.rbusy;

   rvDecoder uDecoder (
      .instr (instr),
      .dec   (dec)
   );

   // Indices come straight from the bus, data ready in EXECUTE
   assign rfRdEn = instrReady;

   rvRegFile uRegFile (
      .clk    (clk),
      .rdEn   (rfRdEn),
      .rs1Idx (fetched.rType.rs1),
      .rs2Idx (fetched.rType.rs2),
      .rs1    (rs1),
      .rs2    (rs2),
      .wrEn   (rfWrEn),
      .rdIdx  (dec.rd),
      .wrData (rfWrData)
   );

   assign aluOp.funct3 = dec.funct3;
   assign aluOp.isSub  = dec.isSub;
   assign aluOp.isSra  = dec.isSra;
   assign aluIn2       = dec.isAluImm ? dec.iImm : rs2;

   rvAlu uAlu (
      .in1       (rs1),
      .in2       (aluIn2),
      .op        (aluOp),
      .result    (aluResult),
      .predicate (predicate)
   );

   rvLoadStore uLoadStore (
      .addrLow  (lsAddr[1:0]),
      .funct3   (dec.funct3),
      .rdata    (memRsp.rdata),
      .rs2      (rs2),
      .loadData (loadData),
      .wdata    (storeData),
      .wmask    (storeMask)
   );

   assign pcPlus4 = pc + ADDR_WIDTH'(4);

   // Shared PC adder operand
   always_comb begin
      if (dec.isJal) pcImm = dec.jImm[ADDR_WIDTH-1:0];
      else if (dec.isAuipc) pcImm = dec.uImm[ADDR_WIDTH-1:0];
      else pcImm = dec.bImm[ADDR_WIDTH-1:0];
   end

   always_comb begin
      if (dec.isJalr) begin
         nextPc = {rs1PlusImm[ADDR_WIDTH-1:1], 1'b0};        // Low bit cleared
      end else if (dec.isJal || (dec.isBranch && predicate)) begin
         nextPc = pcPlusImm;
      end else begin
         nextPc = pcPlus4;
      end
   end

   assign writesRd = dec.isAluImm | dec.isAluReg | dec.isLui | dec.isAuipc
                   | dec.isJal | dec.isJalr;

   // Write-back source
   always_comb begin
      if (dec.isLui) rfWrData = dec.uImm;
      else if (dec.isAuipc) rfWrData = {{ADDR_PAD_WIDTH{1'b0}}, pcPlusImm};
      else if (dec.isJal || dec.isJalr) rfWrData = {{ADDR_PAD_WIDTH{1'b0}}, pcPlus4}; // Link
      else if (dec.isLoad) rfWrData = loadData;
      else rfWrData = aluResult;
   end

   assign rfWrEn = ((state == COMMIT) && writesRd)
                 | ((state == WAIT_MEM) && loadPending && !memRsp.rbusy);

   // Bus outputs
   assign memReq.addr  = {{ADDR_PAD_WIDTH{1'b0}},
                          (state == FETCH || state == WAIT_INSTR) ? pc : lsAddr};
   assign memReq.wdata = storeData;
   assign memReq.wmask = {4{(state == COMMIT) && dec.isStore}} & storeMask;
   assign memReq.rstrb = (state == FETCH) || ((state == COMMIT) && dec.isLoad);

   // Controller
   always_ff @(posedge clk) begin
      if (!reset) begin
         state       <= WAIT_MEM;                            // Wait for idle bus first
         pc          <= RESET_ADDR[ADDR_WIDTH-1:0];
         loadPending <= 1'b0;
      end else begin
         case (state)
            FETCH: state <= WAIT_INSTR;
            WAIT_INSTR: begin
               if (!memRsp.rbusy) state <= EXECUTE;          // Hold while rbusy
            end
            EXECUTE: state <= COMMIT;
            COMMIT: begin
               pc          <= nextPc;
               loadPending <= dec.isLoad;
               state       <= (dec.isLoad || dec.isStore) ? WAIT_MEM : FETCH;
            end
            WAIT_MEM: begin
               if (!memRsp.rbusy) loadPending <= 1'b0;       // Written back this cycle
               if (!memRsp.rbusy && !memRsp.wbusy) state <= FETCH;
            end
            default: state <= WAIT_MEM;
         endcase
      end
   end

   // Instruction latch and address adders
   always_ff @(posedge clk) begin
      if (instrReady) begin
         instr <= fetched;
      end
      if (state == EXECUTE) begin
         pcPlusImm  <= pc + pcImm;
         rs1PlusImm <= rs1[ADDR_WIDTH-1:0] + dec.iImm[ADDR_WIDTH-1:0];
         lsAddr     <= rs1[ADDR_WIDTH-1:0]
                     + (dec.isStore ? dec.sImm[ADDR_WIDTH-1:0] : dec.iImm[ADDR_WIDTH-1:0]);
      end
   end

endmodule

`default_nettype wire

// File: tbProgram.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

int progPc;   // Next instruction slot, byte address
int storeOff; // Next result word, offset from x10

function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                     input logic [2:0] f3, input logic [4:0] rd);
   return {f7, rs2, rs1, f3, rd, OPCODE_OP, 2'b11};
endfunction

function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [4:0] op);
   return {imm, rs1, f3, rd, op, 2'b11};
endfunction

function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                     input logic [2:0] f3);
   return {imm[11:5], rs2, rs1, f3, imm[4:0], OPCODE_STORE, 2'b11};
endfunction

function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                     input logic [2:0] f3);
   return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPCODE_BRANCH, 2'b11};
endfunction

function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                     input logic [4:0] op);
   return {imm, rd, op, 2'b11};
endfunction

function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPCODE_JAL, 2'b11};
endfunction

task automatic put(input logic [31:0] w);
   image[progPc[11:2]] = w;
   progPc += 4;
endtask

task automatic storeReg(input logic [4:0] r);
   put(encS(storeOff[11:0], r, 5'd10, FUNCT3_WORD));
   storeOff += 4;
endtask

task automatic putAndStore(input logic [31:0] w); // Result always in x3
   put(w);
   storeReg(5'd3);
endtask

task automatic buildProgram();
   logic [31:0] rnd;
   logic [4:0]  amounts [4];
   logic [2:0]  kinds [6];
   logic [4:0]  pairA [3];
   logic [4:0]  pairB [3];
   int          k;
   int          p;
   progPc   = int'(RESET_ADDR);
   storeOff = 0;
   amounts  = '{5'd0, 5'd1, 5'd31, 5'd0};
   rnd      = $urandom;
   amounts[3] = rnd[4:0];
   kinds    = '{FUNCT3_BEQ, FUNCT3_BNE, FUNCT3_BLT, FUNCT3_BGE, FUNCT3_BLTU, FUNCT3_BGEU};
   pairA    = '{5'd1, 5'd2, 5'd1};               // Third pair is equal
   pairB    = '{5'd2, 5'd1, 5'd1};
   put(encI(12'h400, 5'd0, FUNCT3_ADD, 5'd10, OPCODE_OPIMM)); // Result base
   rnd = $urandom;
   put(encU(rnd[31:12], 5'd1, OPCODE_LUI));      // x1 and x2 random
   put(encI(rnd[11:0], 5'd1, FUNCT3_ADD, 5'd1, OPCODE_OPIMM));
   rnd = $urandom;
   put(encU(rnd[31:12], 5'd2, OPCODE_LUI));
   put(encI(rnd[11:0], 5'd2, FUNCT3_ADD, 5'd2, OPCODE_OPIMM));
   put(encI(12'hFF9, 5'd0, FUNCT3_ADD, 5'd6, OPCODE_OPIMM)); // x6 = -7
   put(encI(12'h000, 5'd0, FUNCT3_ADD, 5'd7, OPCODE_OPIMM));
   putAndStore(encR(7'h00, 5'd2, 5'd1, FUNCT3_ADD, 5'd3));
   putAndStore(encR(7'h20, 5'd2, 5'd1, FUNCT3_ADD, 5'd3)); // SUB
   putAndStore(encR(7'h20, 5'd1, 5'd6, FUNCT3_ADD, 5'd3));
   putAndStore(encR(7'h00, 5'd2, 5'd1, FUNCT3_XOR, 5'd3));
   putAndStore(encR(7'h00, 5'd2, 5'd1, FUNCT3_OR, 5'd3));
   putAndStore(encR(7'h00, 5'd2, 5'd1, FUNCT3_AND, 5'd3));
   putAndStore(encR(7'h00, 5'd2, 5'd1, FUNCT3_SLT, 5'd3));
   putAndStore(encR(7'h00, 5'd2, 5'd1, FUNCT3_SLTU, 5'd3));
   putAndStore(encR(7'h00, 5'd1, 5'd6, FUNCT3_SLT, 5'd3));
   putAndStore(encR(7'h00, 5'd1, 5'd6, FUNCT3_SLTU, 5'd3));
   putAndStore(encI(12'hF9C, 5'd1, FUNCT3_ADD, 5'd3, OPCODE_OPIMM)); // -100
   putAndStore(encI(12'hFFD, 5'd6, FUNCT3_SLT, 5'd3, OPCODE_OPIMM));
   putAndStore(encI(12'h005, 5'd6, FUNCT3_SLTU, 5'd3, OPCODE_OPIMM));
   putAndStore(encI(12'h5A5, 5'd1, FUNCT3_XOR, 5'd3, OPCODE_OPIMM));
   putAndStore(encI(12'hFFF, 5'd1, FUNCT3_XOR, 5'd3, OPCODE_OPIMM));
   putAndStore(encI(12'h0F0, 5'd6, FUNCT3_OR, 5'd3, OPCODE_OPIMM));
   putAndStore(encI(12'h7F3, 5'd1, FUNCT3_AND, 5'd3, OPCODE_OPIMM));
   for (k = 0; k < 4; k++) begin                 // Shift amounts 0, 1, 31, random
      putAndStore(encI({7'h00, amounts[k]}, 5'd1, FUNCT3_SLL, 5'd3, OPCODE_OPIMM));
      putAndStore(encI({7'h00, amounts[k]}, 5'd1, FUNCT3_SR, 5'd3, OPCODE_OPIMM));
      putAndStore(encI({7'h20, amounts[k]}, 5'd1, FUNCT3_SR, 5'd3, OPCODE_OPIMM));
      putAndStore(encI({7'h20, amounts[k]}, 5'd6, FUNCT3_SR, 5'd3, OPCODE_OPIMM));
   end
   putAndStore(encR(7'h00, 5'd2, 5'd1, FUNCT3_SLL, 5'd3)); // Amount from x2
   putAndStore(encR(7'h00, 5'd2, 5'd1, FUNCT3_SR, 5'd3));
   putAndStore(encR(7'h20, 5'd2, 5'd6, FUNCT3_SR, 5'd3));
   put(encS(12'h200, 5'd1, 5'd10, FUNCT3_BYTE)); // Every byte offset
   put(encS(12'h201, 5'd6, 5'd10, FUNCT3_BYTE));
   put(encS(12'h202, 5'd2, 5'd10, FUNCT3_BYTE));
   put(encS(12'h203, 5'd6, 5'd10, FUNCT3_BYTE));
   put(encS(12'h204, 5'd6, 5'd10, FUNCT3_HALF));
   put(encS(12'h206, 5'd1, 5'd10, FUNCT3_HALF));
   putAndStore(encI(12'h201, 5'd10, 3'b000, 5'd3, OPCODE_LOAD)); // LB
   putAndStore(encI(12'h201, 5'd10, 3'b100, 5'd3, OPCODE_LOAD)); // LBU
   putAndStore(encI(12'h203, 5'd10, 3'b000, 5'd3, OPCODE_LOAD));
   putAndStore(encI(12'h200, 5'd10, 3'b100, 5'd3, OPCODE_LOAD));
   putAndStore(encI(12'h202, 5'd10, 3'b000, 5'd3, OPCODE_LOAD));
   putAndStore(encI(12'h204, 5'd10, 3'b001, 5'd3, OPCODE_LOAD)); // LH
   putAndStore(encI(12'h204, 5'd10, 3'b101, 5'd3, OPCODE_LOAD)); // LHU
   putAndStore(encI(12'h206, 5'd10, 3'b001, 5'd3, OPCODE_LOAD));
   putAndStore(encI(12'h206, 5'd10, 3'b101, 5'd3, OPCODE_LOAD));
   putAndStore(encI(12'h204, 5'd10, FUNCT3_WORD, 5'd3, OPCODE_LOAD));
   for (k = 0; k < 6; k++) begin                 // Taken branch skips the add
      for (p = 0; p < 3; p++) begin
         put(encB(13'd8, pairB[p], pairA[p], kinds[k]));
         put(encI(12'(1 << p), 5'd7, FUNCT3_ADD, 5'd7, OPCODE_OPIMM));
      end
      storeReg(5'd7);
   end
   put(encJ(21'd8, 5'd3));
   put(encI(12'd64, 5'd7, FUNCT3_ADD, 5'd7, OPCODE_OPIMM)); // Skipped
   storeReg(5'd3);
   storeReg(5'd7);
   put(encU(20'd0, 5'd4, OPCODE_AUIPC));
   put(encI(12'd17, 5'd4, FUNCT3_ADD, 5'd4, OPCODE_OPIMM)); // Odd target
   put(encI(12'd0, 5'd4, 3'b000, 5'd3, OPCODE_JALR));
   put(encI(12'd128, 5'd7, FUNCT3_ADD, 5'd7, OPCODE_OPIMM)); // Skipped
   storeReg(5'd3);
   storeReg(5'd4);
   storeReg(5'd7);
   rnd = $urandom;
   putAndStore(encU(rnd[19:0], 5'd3, OPCODE_LUI));
   putAndStore(encU(20'h00003, 5'd3, OPCODE_AUIPC));
   put(encI(12'h05A, 5'd0, FUNCT3_ADD, 5'd3, OPCODE_OPIMM));
   put(encS(12'h3FC, 5'd3, 5'd10, FUNCT3_WORD)); // Marker store
   put(encJ(21'd0, 5'd0));                       // Self-loop
endtask

`endif

// File: tbFemtoCore.sv
`timescale 1ns/1ps
`default_nettype none

module tbFemtoCore;
   import rvIsaPkg::*;
   import coreBusPkg::*;

   localparam logic [31:0] SEED        = 32'h9629_7f0d;
   localparam logic [31:0] MARKER_ADDR = 32'h0000_07FC; // Last store of the program
   localparam int          MEM_WORDS   = 1024;           // 4 KB

   logic        clk = 1'b0;
   logic        reset = 1'b0;
   memReqT      memReq;
   memRspT      memRsp = '0;

   logic [31:0] image   [MEM_WORDS]; // Program and initial data
   logic [31:0] mem     [MEM_WORDS]; // Memory seen by the DUT
   logic [31:0] refMem  [MEM_WORDS];
   logic [31:0] refRegs [32];
   logic [31:0] expAddr [$];         // Expected stores in order
   logic [31:0] expData [$];
   logic [3:0]  expMask [$];
   logic [31:0] eAddr;
   logic [31:0] eData;
   logic [3:0]  eMask;
   int          rLeft = 0;           // Remaining rbusy cycles
   int          wLeft = 0;
   int          instrCount;
   int          cycleLimit;
   int          cycles;
   int          i;
   logic [31:0] refPc;
   logic [31:0] refNext;
   logic        fetchSeen = 1'b0;
   logic        storesDone = 1'b0;

   `include "tbProgram.svh"

   femtoCore uut (
      .clk    (clk),
      .reset  (reset),
      .memReq (memReq),
      .memRsp (memRsp)
   );

   always #4 clk = ~clk;

   task automatic stopOnError();
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic failRun(input string why);
      $display("%s at time %0t", why, $time);
      stopOnError();
   endtask

   task automatic checkValue(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
      if (actual !== expected) begin
         $display("FAIL t=%0t %s got %h expected %h", $time, name, actual, expected);
         stopOnError();
      end
   endtask

   // 1 in 4 accesses stall for 1 to 3 cycles
   function automatic int stallLength();
      if ($urandom % 4 == 0) return 1 + int'($urandom % 3);
      return 0;
   endfunction

   function automatic logic [31:0] laneBits(input logic [3:0] m);
      return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
   endfunction

   function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a, b);
      case (f3)
         FUNCT3_BEQ:  return a == b;
         FUNCT3_BNE:  return a != b;
         FUNCT3_BLT:  return $signed(a) < $signed(b);
         FUNCT3_BGE:  return $signed(a) >= $signed(b);
         FUNCT3_BLTU: return a < b;
         FUNCT3_BGEU: return a >= b;
         default:     return 1'b0;
      endcase
   endfunction

   function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic [31:0] a, b,
                                          input logic sub, input logic arith);
      case (f3)
         FUNCT3_ADD:  return sub ? a - b : a + b;
         FUNCT3_SLL:  return a << b[4:0];
         FUNCT3_SLT:  return {31'd0, $signed(a) < $signed(b)};
         FUNCT3_SLTU: return {31'd0, a < b};
         FUNCT3_XOR:  return a ^ b;
         FUNCT3_SR:   return arith ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
         FUNCT3_OR:   return a | b;
         default:     return a & b;
      endcase
   endfunction

   // Executes one instruction on the reference model and returns the next PC
   function automatic logic [31:0] refStep(input logic [31:0] pc);
      logic [31:0] ins;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic [31:0] addr;
      logic [31:0] nextPc;
      logic [31:0] iImm;
      logic [31:0] sImm;
      logic [31:0] word;
      logic [31:0] data;
      logic [3:0]  mask;
      logic [4:0]  lane;
      logic        wr;
      int          k;
      ins    = refMem[pc[11:2]];
      a      = refRegs[ins[19:15]];
      b      = refRegs[ins[24:20]];
      iImm   = {{20{ins[31]}}, ins[31:20]};
      sImm   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      nextPc = pc + 32'd4;
      res    = 32'd0;
      wr     = 1'b0;
      case (ins[6:2])
         OPCODE_LUI: begin
            res = {ins[31:12], 12'b0};
            wr  = 1'b1;
         end
         OPCODE_AUIPC: begin
            res = pc + {ins[31:12], 12'b0};
            wr  = 1'b1;
         end
         OPCODE_JAL: begin
            res    = pc + 32'd4;                     // Link
            nextPc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            wr     = 1'b1;
         end
         OPCODE_JALR: begin
            res    = pc + 32'd4;
            nextPc = (a + iImm) & ~32'd1;            // Low bit cleared
            wr     = 1'b1;
         end
         OPCODE_BRANCH: begin
            if (branchTaken(ins[14:12], a, b))
               nextPc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
         end
         OPCODE_LOAD: begin
            addr = a + iImm;
            word = refMem[addr[11:2]] >> {addr[1:0], 3'b000};
            case (ins[14:12])
               3'b000:  res = {{24{word[7]}}, word[7:0]};
               3'b001:  res = {{16{word[15]}}, word[15:0]};
               3'b100:  res = {24'd0, word[7:0]};
               3'b101:  res = {16'd0, word[15:0]};
               default: res = word;
            endcase
            wr = 1'b1;
         end
         OPCODE_STORE: begin
            addr = a + sImm;
            lane = {addr[1:0], 3'b000};
            case (ins[13:12])
               2'b00: begin
                  mask = 4'b0001 << addr[1:0];
                  data = {24'd0, b[7:0]} << lane;
               end
               2'b01: begin
                  mask = 4'b0011 << addr[1:0];
                  data = {16'd0, b[15:0]} << lane;
               end
               default: begin
                  mask = 4'b1111;
                  data = b;
               end
            endcase
            for (k = 0; k < 4; k++) begin
               if (mask[k]) refMem[addr[11:2]][8*k +: 8] = data[8*k +: 8];
            end
            expAddr.push_back(addr);
            expData.push_back(data);
            expMask.push_back(mask);
         end
         OPCODE_OP: begin
            res = aluRef(ins[14:12], a, b, ins[30], ins[30]);
            wr  = 1'b1;
         end
         OPCODE_OPIMM: begin
            res = aluRef(ins[14:12], a, iImm, 1'b0, ins[30]); // No SUBI
            wr  = 1'b1;
         end
         default: ;                                  // SYSTEM is a no-op
      endcase
      if (wr && ins[11:7] != 5'd0) refRegs[ins[11:7]] = res;
      return nextPc;
   endfunction

   // Memory model with random back-pressure
   always @(posedge clk) begin : memModel
      int n;
      int k;
      if (!reset) begin
         mem <= image;
      end else begin
         if (memReq.rstrb) begin
            n = stallLength();
            memRsp.rdata <= mem[memReq.addr[11:2]];
            memRsp.rbusy <= (n != 0);
            rLeft        <= n;
         end else if (rLeft > 1) begin
            rLeft <= rLeft - 1;
         end else begin
            rLeft        <= 0;
            memRsp.rbusy <= 1'b0;
         end
         if (memReq.wmask != 4'b0) begin
            n = stallLength();
            for (k = 0; k < 4; k++) begin
               if (memReq.wmask[k])
                  mem[memReq.addr[11:2]][8*k +: 8] <= memReq.wdata[8*k +: 8];
            end
            memRsp.wbusy <= (n != 0);
            wLeft        <= n;
         end else if (wLeft > 1) begin
            wLeft <= wLeft - 1;
         end else begin
            wLeft        <= 0;
            memRsp.wbusy <= 1'b0;
         end
      end
   end

   // Compare DUT writes with the reference store list
   always @(posedge clk) begin
      if (reset && memReq.rstrb && !fetchSeen) begin
         checkValue("memReq.addr", memReq.addr, RESET_ADDR); // First fetch
         fetchSeen <= 1'b1;
      end
      if (!reset && (memReq.wmask != 4'b0 || memReq.rstrb)) begin
         failRun("Bus request issued while reset was held");
      end
      if (reset && memReq.wmask != 4'b0) begin
         if (expAddr.size() == 0) begin
            failRun("DUT wrote more often than the reference program stores");
         end else begin
            eAddr = expAddr.pop_front();
            eData = expData.pop_front();
            eMask = expMask.pop_front();
            checkValue("memReq.addr", memReq.addr, eAddr);
            checkValue("memReq.wmask", {28'd0, memReq.wmask}, {28'd0, eMask});
            checkValue("memReq.wdata", memReq.wdata & laneBits(memReq.wmask), eData);
            if (eAddr == MARKER_ADDR) storesDone <= 1'b1;   // Final store matched
         end
      end
   end

   initial begin
      void'($urandom(SEED));
      for (i = 0; i < MEM_WORDS; i++) begin
         image[i] = 32'(i) * 32'h9E37_79B1;          // Multiplicative hash of the word index
      end
      buildProgram();
      for (i = 0; i < MEM_WORDS; i++) refMem[i] = image[i];
      for (i = 0; i < 32; i++) refRegs[i] = 32'd0;
      // Run the reference up to the self-loop
      refPc      = RESET_ADDR;
      instrCount = 0;
      while (instrCount < 4000) begin
         refNext    = refStep(refPc);
         instrCount = instrCount + 1;
         if (refNext == refPc) break;
         refPc = refNext;
      end
      cycleLimit = 5 * instrCount * 8;
      repeat (10) @(posedge clk);
      reset <= 1'b1;
      cycles = 0;
      while (!storesDone && cycles < cycleLimit) begin
         @(posedge clk);
         cycles = cycles + 1;
      end
      if (storesDone) begin
         $display("Test passed");
         $finish;
      end else begin
         failRun("Timeout before the marker store was seen");
      end
   end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
rvIsaPkg.sv
coreBusPkg.sv
rvDecoder.sv
rvAlu.sv
rvLoadStore.sv
rvRegFile.sv
femtoCore.sv
tbFemtoCore.sv

// File: runSim.sh
#!/bin/sh
# Build and run the femtoCore testbench with Verilator
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f src.f \
   --top-module tbFemtoCore -o tbFemtoCore
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tbFemtoCore > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if [ $simStatus -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi

if grep -qx "Test passed" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1
